// File: source/upPkg.sv
package upPkg;

	// First byte of every two-byte instruction
	typedef enum logic [7:0] {
		opNop = 8'h00,
		opLdi = 8'h01,
		opLda = 8'h02,
		opSta = 8'h03,
		opAdd = 8'h04,
		opSub = 8'h05,
		opAnd = 8'h06,
		opOr  = 8'h07,
		opXor = 8'h08,
		opJmp = 8'h09,
		opJz  = 8'h0A,
		opOut = 8'h0B,
		opHlt = 8'h0C
	} opcode_t;

	typedef enum logic [2:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor
	} aluOp_t;

	// Memory request as driven by the controller
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] wdata;
		logic       we;
	} memReq_t;

	// Access from the host port, only honoured while the core is idle
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
		logic       we;
	} hostReq_t;

	// Contents of addresses 0 to 10 after reset
	localparam logic [0:10][7:0] bootImage = {
		8'h12, 8'h34, 8'h56, 8'h78, 8'h9A, 8'hBC,
		8'hDE, 8'hF0, 8'h08, 8'h09, 8'h0A
	};

endpackage

// File: source/upAlu.sv
`timescale 1ns/1ps

module upAlu (
	input  upPkg::aluOp_t op,
	input  logic [7:0]    a,
	input  logic [7:0]    b,
	output logic [7:0]    result,
	output logic          zero
);

	// All arithmetic wraps modulo 256, there is no carry out
	always_comb begin
		case (op)
			upPkg::aluAdd: begin
				result = a + b;
			end
			upPkg::aluSub: begin
				result = a - b;
			end
			upPkg::aluAnd: begin
				result = a & b;
			end
			upPkg::aluOr: begin
				result = a | b;
			end
			upPkg::aluXor: begin
				result = a ^ b;
			end
			default: begin
				// Pass forwards the operand for loads
				result = b;
			end
		endcase
	end

	assign zero = (result == 8'h00);

endmodule

// File: source/upMemory.sv
`timescale 1ns/1ps

module upMemory (
	input  logic           clk,
	input  logic           nRst,
	input  upPkg::memReq_t req,
	output logic [7:0]     rdata,
	output logic           settled
);

	logic [7:0] mem [256];
	logic       writeChanges;

	// A write that alters the addressed byte leaves rdata stale for a cycle
	assign writeChanges = req.we && (req.wdata != mem[req.addr]);

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= 8'h00;
			end
			// Boot image overrides the cleared locations at the bottom
			for (int i = 0; i < $size(upPkg::bootImage); i++) begin
				mem[i] <= upPkg::bootImage[i];
			end
			rdata   <= 8'h00;
			settled <= 1'b0;
		end else begin
			if (req.we) begin
				mem[req.addr] <= req.wdata;
			end
			rdata   <= mem[req.addr];
			settled <= !writeChanges && (rdata == mem[req.addr]);
		end
	end

	// A settled read shows the byte now stored at the address it was issued for
	settledIsCurrent: assert property (
		@(posedge clk) disable iff (!nRst)
		settled |-> (rdata == mem[$past(req.addr)])
	) else $error("settled high while rdata differs from the byte at the read address");

endmodule

// File: source/upControl.sv
`timescale 1ns/1ps

module upControl #(
	parameter logic [7:0] ResetVector = 8'h10
) (
	input  logic            clk,
	input  logic            nRst,
	input  logic            start,
	input  upPkg::hostReq_t host,
	output upPkg::memReq_t  memReq,
	input  logic [7:0]      rdata,
	input  logic            settled,
	output upPkg::aluOp_t   aluOp,
	output logic [7:0]      aluA,
	output logic [7:0]      aluB,
	input  logic [7:0]      aluResult,
	input  logic            aluZero,
	output logic [7:0]      outPort,
	output logic            outValid,
	output logic            busy,
	output logic            zeroFlag
);

	typedef enum logic [2:0] {
		idle,
		fetchOp,
		fetchArg,
		readData,
		execute
	} state_t;

	state_t           state;
	upPkg::opcode_t   opReg;
	logic [7:0]       pc;
	logic [7:0]       acc;
	logic [7:0]       arg;
	logic             zero;
	logic             armed;
	logic             needsData;
	logic             readDone;

	// settled may still describe the previous address in the first cycle of a state
	assign readDone = armed && settled;

	assign needsData = opReg inside {upPkg::opLda, upPkg::opAdd, upPkg::opSub,
		upPkg::opAnd, upPkg::opOr, upPkg::opXor};

	assign busy     = (state != idle);
	assign zeroFlag = zero;
	assign aluA     = acc;
	assign aluB     = arg;

	always_comb begin
		case (opReg)
			upPkg::opAdd: aluOp = upPkg::aluAdd;
			upPkg::opSub: aluOp = upPkg::aluSub;
			upPkg::opAnd: aluOp = upPkg::aluAnd;
			upPkg::opOr:  aluOp = upPkg::aluOr;
			upPkg::opXor: aluOp = upPkg::aluXor;
			default:      aluOp = upPkg::aluPass;
		endcase
	end

	// Host owns the memory while idle, the core otherwise
	always_comb begin
		memReq = '0;
		case (state)
			idle: begin
				memReq.addr  = host.addr;
				memReq.wdata = host.data;
				memReq.we    = host.we;
			end
			fetchOp, fetchArg: begin
				memReq.addr = pc;
			end
			default: begin
				memReq.addr  = arg;
				memReq.wdata = acc;
				memReq.we    = (state == execute) && (opReg == upPkg::opSta);
			end
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state    <= idle;
			opReg    <= upPkg::opNop;
			pc       <= ResetVector;
			acc      <= 8'h00;
			arg      <= 8'h00;
			zero     <= 1'b0;
			armed    <= 1'b0;
			outPort  <= 8'h00;
			outValid <= 1'b0;
		end else begin
			outValid <= 1'b0;
			armed    <= 1'b1;
			case (state)
				idle: begin
					if (start) begin
						pc    <= ResetVector;
						state <= fetchOp;
						armed <= 1'b0;
					end
				end
				fetchOp: begin
					if (readDone) begin
						opReg <= upPkg::opcode_t'(rdata);
						pc    <= pc + 8'd1;
						state <= fetchArg;
						armed <= 1'b0;
					end
				end
				fetchArg: begin
					if (readDone) begin
						arg   <= rdata;
						pc    <= pc + 8'd1;
						state <= needsData ? readData : execute;
						armed <= 1'b0;
					end
				end
				readData: begin
					// The address is no longer needed, arg now holds the memory operand
					if (readDone) begin
						arg   <= rdata;
						state <= execute;
						armed <= 1'b0;
					end
				end
				execute: begin
					state <= fetchOp;
					armed <= 1'b0;
					if (opReg == upPkg::opLdi || needsData) begin
						acc  <= aluResult;
						zero <= aluZero;
					end
					case (opReg)
						upPkg::opJmp: pc <= arg;
						upPkg::opJz: begin
							if (zero) begin
								pc <= arg;
							end
						end
						upPkg::opOut: begin
							outPort  <= acc;
							outValid <= 1'b1;
						end
						upPkg::opHlt: state <= idle;
						default: ;
					endcase
				end
				default: state <= idle;
			endcase
		end
	end

	outOnlyWhenBusy: assert property (
		@(posedge clk) disable iff (!nRst)
		outValid |-> busy
	) else $error("outValid raised while the core is idle");

	noWriteOnFetch: assert property (
		@(posedge clk) disable iff (!nRst)
		memReq.we |-> !(state inside {fetchOp, fetchArg})
	) else $error("memory write issued during an instruction fetch");

endmodule

// File: source/upTop.sv
`timescale 1ns/1ps

module upTop #(
	parameter logic [7:0] ResetVector = 8'h10
) (
	input  logic            clk,
	input  logic            nRst,
	input  logic            start,
	input  upPkg::hostReq_t host,
	output logic [7:0]      hostRdata,
	output logic            hostReady,
	output logic [7:0]      outPort,
	output logic            outValid,
	output logic            busy,
	output logic            zeroFlag
);

	upPkg::memReq_t memReq;
	upPkg::aluOp_t  aluOp;
	logic [7:0]     aluA;
	logic [7:0]     aluB;
	logic [7:0]     aluResult;
	logic           aluZero;

	upControl #(
		.ResetVector(ResetVector)
	) i_upControl (
		.clk      (clk),
		.nRst     (nRst),
		.start    (start),
		.host     (host),
		.memReq   (memReq),
		.rdata    (hostRdata),
		.settled  (hostReady),
		.aluOp    (aluOp),
		.aluA     (aluA),
		.aluB     (aluB),
		.aluResult(aluResult),
		.aluZero  (aluZero),
		.outPort  (outPort),
		.outValid (outValid),
		.busy     (busy),
		.zeroFlag (zeroFlag)
	);

	upAlu i_upAlu (
		.op    (aluOp),
		.a     (aluA),
		.b     (aluB),
		.result(aluResult),
		.zero  (aluZero)
	);

	// Read data and settled level are shared by the core and the host port
	upMemory i_upMemory (
		.clk    (clk),
		.nRst   (nRst),
		.req    (memReq),
		.rdata  (hostRdata),
		.settled(hostReady)
	);

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	input  logic rstReq,
	output logic clk,
	output logic nRst
);

	logic powerOn;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Power-on reset covers the first two rising edges
	initial begin
		powerOn = 1'b1;
		repeat (2) @(posedge clk);
		powerOn <= 1'b0;
	end

	assign nRst = !(powerOn || rstReq);

endmodule

// File: sim/tbChecker.sv
`timescale 1ns/1ps

module tbChecker (
	input  logic       clk,
	input  logic       nRst,
	input  logic [7:0] hostRdata,
	input  logic [7:0] outPort,
	input  logic       outValid,
	input  logic       busy,
	input  logic       zeroFlag,
	input  logic       checkEn,
	input  logic [1:0] checkSel,
	input  logic [7:0] checkExp,
	input  logic [1:0] failCode,
	input  logic       testEnd,
	input  int         testIdx,
	input  int         expCount,
	input  logic [7:0] expOuts [8],
	input  logic       runEnd,
	output int         errors
);

	logic [7:0] seen [16];
	logic [7:0] actual;
	string      sigName;
	int         seenCount;
	int         testErrors;
	int         testChecks;
	int         checks;
	int         tests;

	initial begin
		errors     = 0;
		seenCount  = 0;
		testErrors = 0;
		testChecks = 0;
		checks     = 0;
		tests      = 0;
	end

	// Everything is sampled on the falling edge, half a cycle after the DUT moved
	always @(negedge clk) begin
		if (nRst && outValid) begin
			if (seenCount < 16) begin
				seen[seenCount[3:0]] = outPort;
			end
			seenCount++;
		end
		if (checkEn) begin
			case (checkSel)
				2'd0: begin
					actual  = hostRdata;
					sigName = "hostRdata";
				end
				2'd1: begin
					actual  = {7'd0, busy};
					sigName = "busy";
				end
				2'd2: begin
					actual  = {7'd0, outValid};
					sigName = "outValid";
				end
				default: begin
					actual  = {7'd0, zeroFlag};
					sigName = "zeroFlag";
				end
			endcase
			testChecks++;
			if (actual !== checkExp) begin
				$display("[ERROR] test %0d %s expected %h got %h", testIdx, sigName, checkExp, actual);
				testErrors++;
			end
		end
		case (failCode)
			2'd1: $display("test %0d: busy never dropped, the program did not halt", testIdx);
			2'd2: $display("test %0d: hostReady never rose after a host read", testIdx);
			2'd3: $display("test %0d: no outValid strobe came while the program ran", testIdx);
			default: ;
		endcase
		if (failCode != 2'd0) begin
			testErrors++;
		end
		if (testEnd) begin
			testChecks++;
			if (seenCount != expCount) begin
				$display("[ERROR] test %0d outValid count expected %h got %h",
					testIdx, expCount, seenCount);
				testErrors++;
			end else begin
				for (int i = 0; i < expCount; i++) begin
					testChecks++;
					if (seen[i] !== expOuts[i]) begin
						$display("[ERROR] test %0d outPort expected %h got %h",
							testIdx, expOuts[i], seen[i]);
						testErrors++;
					end
				end
			end
			$display("test %0d %s: %0d checks, %0d errors", testIdx,
				(testErrors == 0) ? "ok" : "failed", testChecks, testErrors);
			errors     += testErrors;
			checks     += testChecks;
			testErrors = 0;
			testChecks = 0;
			seenCount  = 0;
			tests++;
		end
		if (runEnd) begin
			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		end
	end

endmodule

// File: sim/tbUp.sv
`timescale 1ns/1ps

module tbUp;

	localparam logic [7:0] ResetVector = 8'h10;
	localparam int NumPrograms = 3;
	// Instructions executed by each table program, the reset test reruns program 1
	localparam int instrCount [NumPrograms] = '{13, 13, 5};

	logic            clk;
	logic            nRst;
	logic            rstReq;
	logic            start;
	upPkg::hostReq_t host;
	logic [7:0]      hostRdata;
	logic [7:0]      outPort;
	logic            hostReady;
	logic            outValid;
	logic            busy;
	logic            zeroFlag;

	logic       checkEn;
	logic [1:0] checkSel;
	logic [7:0] checkExp;
	logic [1:0] failCode;
	logic       testEnd;
	logic       runEnd;
	int         testIdx;
	int         expCount;
	int         errors;
	logic [7:0] expOuts [8];
	logic [15:0] lfsr;

	// Test table, one entry per program
	logic [7:0]      progBytes [NumPrograms][$];
	logic [7:0]      progOuts  [NumPrograms][$];
	logic [7:0]      preAddr   [NumPrograms][$];
	logic [7:0]      preVal    [NumPrograms][$];
	logic [7:0]      rbAddr    [NumPrograms][$];
	logic [7:0]      rbVal     [NumPrograms][$];
	logic            zeroExp   [NumPrograms];
	upPkg::hostReq_t busyReq   [NumPrograms];

	tbClock i_tbClock (.rstReq(rstReq), .clk(clk), .nRst(nRst));

	upTop #(
		.ResetVector(ResetVector)
	) i_upTop (
		.clk      (clk),
		.nRst     (nRst),
		.start    (start),
		.host     (host),
		.hostRdata(hostRdata),
		.hostReady(hostReady),
		.outPort  (outPort),
		.outValid (outValid),
		.busy     (busy),
		.zeroFlag (zeroFlag)
	);

	tbChecker i_tbChecker (
		.clk(clk), .nRst(nRst), .hostRdata(hostRdata), .outPort(outPort),
		.outValid(outValid), .busy(busy), .zeroFlag(zeroFlag),
		.checkEn(checkEn), .checkSel(checkSel), .checkExp(checkExp),
		.failCode(failCode), .testEnd(testEnd), .testIdx(testIdx),
		.expCount(expCount), .expOuts(expOuts), .runEnd(runEnd), .errors(errors)
	);

	task automatic buildTable;
		// ALU chain, each step followed by an OUT
		progBytes[0] = '{8'h01, 8'h5A, 8'h0B, 8'h00, 8'h04, 8'h30, 8'h0B, 8'h00,
			8'h05, 8'h31, 8'h0B, 8'h00, 8'h06, 8'h32, 8'h0B, 8'h00,
			8'h07, 8'h33, 8'h0B, 8'h00, 8'h08, 8'h34, 8'h0B, 8'h00, 8'h0C, 8'h00};
		preAddr[0]   = '{8'h30, 8'h31, 8'h32, 8'h33, 8'h34};
		preVal[0]    = '{8'hC3, 8'h2E, 8'h3C, 8'h81, 8'hFF};
		progOuts[0]  = '{8'h5A, 8'h1D, 8'hEF, 8'h2C, 8'hAD, 8'h52};
		rbAddr[0]    = '{8'h30};
		rbVal[0]     = '{8'hC3};
		zeroExp[0]   = 1'b0;
		busyReq[0]   = '0;
		// Countdown from 3, subtracting the 1 held at 0x30
		progBytes[1] = '{8'h01, 8'h03, 8'h0B, 8'h00, 8'h05, 8'h30, 8'h0A, 8'h1A,
			8'h09, 8'h12, 8'h0C, 8'h00};
		preAddr[1]   = '{8'h30};
		preVal[1]    = '{8'h01};
		progOuts[1]  = '{8'h03, 8'h02, 8'h01};
		rbAddr[1]    = '{8'h30};
		rbVal[1]     = '{8'h01};
		zeroExp[1]   = 1'b1;
		busyReq[1]   = '0;
		// Store, with a host write to 0x52 attempted while running
		progBytes[2] = '{8'h01, 8'hA7, 8'h03, 8'h50, 8'h00, 8'h00, 8'h00, 8'h00, 8'h0C, 8'h00};
		preAddr[2]   = '{8'h52};
		preVal[2]    = '{8'h11};
		progOuts[2].delete();
		rbAddr[2]    = '{8'h50, 8'h52};
		rbVal[2]     = '{8'hA7, 8'h11};
		zeroExp[2]   = 1'b0;
		busyReq[2]   = '{addr: 8'h52, data: 8'h3C, we: 1'b1};
	endtask

	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic randomByte(output logic [7:0] v);
		for (int i = 0; i < 8; i++) begin
			v    = {v[6:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
	endtask

	task automatic hostWrite(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		host <= '{addr: addr, data: data, we: 1'b1};
	endtask

	task automatic hostIdle;
		@(posedge clk);
		host.we <= 1'b0;
	endtask

	task automatic compareSignal(input logic [1:0] sel, input logic [7:0] exp);
		@(posedge clk);
		checkSel <= sel;
		checkExp <= exp;
		checkEn  <= 1'b1;
		@(posedge clk);
		checkEn <= 1'b0;
	endtask

	task automatic raiseFail(input logic [1:0] code);
		@(posedge clk);
		failCode <= code;
		@(posedge clk);
		failCode <= 2'd0;
	endtask

	task automatic hostRead(input logic [7:0] addr, input logic [7:0] exp);
		int waited;
		@(posedge clk);
		host <= '{addr: addr, data: 8'h00, we: 1'b0};
		@(posedge clk);
		waited = 0;
		@(negedge clk);
		while (!hostReady && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		if (!hostReady) begin
			raiseFail(2'd2);
		end else begin
			compareSignal(2'd0, exp);
		end
	endtask

	task automatic loadProgram(input int t);
		for (int i = 0; i < preAddr[t].size(); i++) begin
			hostWrite(preAddr[t][i], preVal[t][i]);
		end
		for (int i = 0; i < progBytes[t].size(); i++) begin
			hostWrite(ResetVector + 8'(i), progBytes[t][i]);
		end
		hostIdle();
	endtask

	task automatic startProgram;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		if (!busy) begin
			compareSignal(2'd1, 8'h01);
		end
	endtask

	task automatic setOuts(input int t, input int count);
		for (int i = 0; i < 8; i++) begin
			expOuts[i] = (i < count) ? progOuts[t][i] : 8'h00;
		end
	endtask

	task automatic finishTest(input int count);
		@(posedge clk);
		expCount <= count;
		testEnd  <= 1'b1;
		@(posedge clk);
		testEnd <= 1'b0;
	endtask

	task automatic runProgram(input int t);
		int waited;
		@(posedge clk);
		testIdx <= t + 2;
		loadProgram(t);
		startProgram();
		if (busyReq[t].we) begin
			hostWrite(busyReq[t].addr, busyReq[t].data);
			hostIdle();
		end
		waited = 0;
		@(negedge clk);
		while (busy && waited < instrCount[t] * 40) begin
			@(negedge clk);
			waited++;
		end
		if (busy) begin
			raiseFail(2'd1);
		end
		compareSignal(2'd3, {7'd0, zeroExp[t]});
		for (int i = 0; i < rbAddr[t].size(); i++) begin
			hostRead(rbAddr[t][i], rbVal[t][i]);
		end
		setOuts(t, progOuts[t].size());
		finishTest(progOuts[t].size());
	endtask

	// Limit follows from the instruction count of every program run
	initial begin : watchdog
		int limit;
		limit = 2000 + instrCount[1] * 40;
		for (int i = 0; i < NumPrograms; i++) begin
			limit += instrCount[i] * 40;
		end
		repeat (limit) @(posedge clk);
		$display("Run stopped by the watchdog after %0d cycles", limit);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		logic [7:0] a;
		logic [7:0] d;
		int waited;
		start    = 1'b0;
		host     = '0;
		rstReq   = 1'b0;
		checkEn  = 1'b0;
		checkSel = 2'd0;
		checkExp = 8'h00;
		failCode = 2'd0;
		testEnd  = 1'b0;
		runEnd   = 1'b0;
		testIdx  = 0;
		expCount = 0;
		lfsr     = 16'd51294;
		for (int i = 0; i < 8; i++) begin
			expOuts[i] = 8'h00;
		end
		buildTable();
		wait (nRst);

		// Test 0 checks the reset image
		compareSignal(2'd1, 8'h00);
		compareSignal(2'd2, 8'h00);
		for (int i = 0; i < 11; i++) begin
			hostRead(8'(i), upPkg::bootImage[i]);
		end
		for (int i = 0; i < 16; i++) begin
			randomByte(a);
			if (a < 8'd11) a = a + 8'd11;
			hostRead(a, 8'h00);
		end
		finishTest(0);

		@(posedge clk);
		testIdx <= 1;
		for (int i = 0; i < 8; i++) begin
			randomByte(a);
			if (a < 8'd11) a = a + 8'd11;
			randomByte(d);
			hostWrite(a, d);
			hostIdle();
			hostRead(a, d);
		end
		finishTest(0);

		for (int t = 0; t < NumPrograms; t++) begin
			runProgram(t);
		end

		// Test 5 resets the countdown right after its first output
		@(posedge clk);
		testIdx <= 5;
		loadProgram(1);
		startProgram();
		waited = 0;
		@(negedge clk);
		while (!outValid && waited < 200) begin
			@(negedge clk);
			waited++;
		end
		if (!outValid) begin
			raiseFail(2'd3);
		end
		@(posedge clk);
		rstReq <= 1'b1;
		compareSignal(2'd1, 8'h00);
		compareSignal(2'd2, 8'h00);
		@(posedge clk);
		rstReq <= 1'b0;
		for (int i = 0; i < 11; i++) begin
			hostRead(8'(i), upPkg::bootImage[i]);
		end
		hostRead(8'h10, 8'h00);
		hostRead(8'h30, 8'h00);
		hostRead(8'h50, 8'h00);
		for (int i = 0; i < 4; i++) begin
			randomByte(a);
			if (a < 8'd11) a = a + 8'd11;
			hostRead(a, 8'h00);
		end
		setOuts(1, 1);
		finishTest(1);

		@(posedge clk);
		runEnd <= 1'b1;
		@(posedge clk);
		runEnd <= 1'b0;
		@(posedge clk);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: files.f
source/upPkg.sv
source/upAlu.sv
source/upMemory.sv
source/upControl.sv
source/upTop.sv
sim/tbClock.sv
sim/tbChecker.sv
sim/tbUp.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tbUp
FILELIST  := files.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass or fail is read from the simulator output
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir
